// File: dv/dmem_input.txt
// we size addr wdata exp_rdata waits err mis, hex; size 0 byte, 1 halfword, 2 word
// exp_rdata is the whole HRDATA word; waits F picks 0 to 3 at random
1 2 00000010 11223344 00000000 0 0 0
0 2 00000010 00000000 11223344 0 0 0
1 2 00000020 55667788 00000000 0 0 0
1 1 00000022 beef0000 00000000 1 0 0
1 0 00000021 0000aa00 00000000 0 0 0
0 2 00000020 00000000 beefaa88 0 0 0
0 0 00000023 00000000 beefaa88 2 0 0
0 1 00000020 00000000 beefaa88 0 0 0
0 2 00000040 00000000 a5103c40 3 0 0
1 1 00000031 12340000 00000000 0 0 1
0 2 00000012 00000000 00000000 0 0 1
0 1 00000022 00000000 beefaa88 0 0 0
1 2 00000050 cafef00d 00000000 0 1 0
0 2 00000050 00000000 a5143c50 0 0 0
0 2 00000010 00000000 00000000 1 1 0
0 2 00000010 00000000 11223344 0 0 0
1 2 00000034 0badf00d 00000000 F 0 0
1 0 00000036 00990000 00000000 F 0 0
0 2 00000013 00000000 00000000 F 0 1
0 2 00000034 00000000 0b99f00d F 0 0
0 0 00000035 00000000 0b99f00d F 0 0
1 1 00000008 00005a5a 00000000 F 1 0
0 2 00000008 00000000 a5023c08 F 0 0
0 2 00000020 00000000 beefaa88 0 0 0

// File: all.f
source/biu_pkg.sv
source/ahb3lite_pkg.sv
source/dmem_decode.sv
source/ahb_master.sv
source/dmem_response.sv
source/dmem_ahb_top.sv
dv/tb_clock.sv
dv/tb_dmem_ahb.sv

// File: Makefile
# Verilator flow for the data memory AHB3-Lite path

TOP := tb_dmem_ahb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

# The run exits non-zero when the testbench stops with $$fatal
sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: dv/tb_dmem_ahb.sv
////////////////////////////////////////////////////////////
// Testbench for the data memory AHB3-Lite path
// Replays input file requests back to back against a slave model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_dmem_ahb;

  localparam int XLEN    = 32;
  localparam int MAX_REQ = 64;
  localparam int TIMEOUT = 100;

  // AHB3-Lite HTRANS and HBURST codes
  localparam logic [1:0] TRANS_IDLE   = 2'b00;
  localparam logic [1:0] TRANS_NONSEQ = 2'b10;
  localparam logic [2:0] BURST_SINGLE = 3'b000;

  logic clk;
  logic rst_n;

  // CPU side
  logic dmem_req, dmem_we, dmem_req_ack, dmem_ack, dmem_err, dmem_misaligned;
  logic [XLEN-1:0] dmem_adr, dmem_d, dmem_q;
  biu_pkg::biu_size_t dmem_size;
  biu_pkg::prv_t      dmem_prv;

  // Bus side with slave outputs starting ready and OKAY
  logic [XLEN-1:0] haddr, hwdata;
  logic            hwrite, hmastlock;
  ahb3lite_pkg::hsize_t  hsize;
  ahb3lite_pkg::hburst_t hburst;
  ahb3lite_pkg::hprot_t  hprot;
  ahb3lite_pkg::htrans_t htrans;
  logic [XLEN-1:0] hrdata = '0;
  logic            hready = 1'b1;
  logic            hresp  = 1'b0;

  //////////////////////////////////////////////////////////
  // Request table from the input file
  //////////////////////////////////////////////////////////
  logic [31:0] r_adr [MAX_REQ];
  logic [31:0] r_wdata [MAX_REQ];
  logic [31:0] r_rdata [MAX_REQ];
  logic [1:0]  r_size [MAX_REQ];
  logic        r_we [MAX_REQ];
  logic        r_err [MAX_REQ];
  logic        r_mis [MAX_REQ];
  int          r_waits [MAX_REQ];
  int          acc_edge [MAX_REQ];
  int          stalls [MAX_REQ];
  int          nreq;
  int          cur_id = 0;
  int          cycle = 0;
  int          pend_q[$];
  int          bus_q[$];
  integer      seed;

  // Slave memory and data phase state
  logic [31:0] mem [64];
  logic        dp_active = 1'b0;
  logic        dp_write, dp_err, err_half;
  logic [31:0] dp_addr;
  logic [2:0]  dp_size;
  int          dp_id, dp_waits;
  logic        nx_hready = 1'b1;
  logic        nx_hresp = 1'b0;
  logic [31:0] nx_hrdata = '0;

  tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(10)) clock_i (.clk_o(clk), .rst_n_o(rst_n));

  dmem_ahb_top #(
    .XLEN ( XLEN ),
    .ALEN ( XLEN )
  )
  dut_i (
    .hclk_i (clk), .rst_n_i (rst_n),
    .dmem_req_i (dmem_req), .dmem_adr_i (dmem_adr), .dmem_size_i (dmem_size),
    .dmem_we_i (dmem_we), .dmem_d_i (dmem_d), .dmem_prv_i (dmem_prv),
    .dmem_req_ack_o (dmem_req_ack), .dmem_ack_o (dmem_ack), .dmem_err_o (dmem_err),
    .dmem_misaligned_o (dmem_misaligned), .dmem_q_o (dmem_q),
    .haddr_o (haddr), .hwdata_o (hwdata), .hwrite_o (hwrite), .hsize_o (hsize),
    .hburst_o (hburst), .hprot_o (hprot), .htrans_o (htrans), .hmastlock_o (hmastlock),
    .hrdata_i (hrdata), .hready_i (hready), .hresp_i (hresp)
  );

  //////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act)
    begin
      $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act);
      abort_run($sformatf("%s has a wrong value", name));
    end
  endtask

  function automatic string req_name(input int id, input string what);
    return $sformatf("req%0d_%s", id, what);
  endfunction

  // Privilege cycles through all four levels
  function automatic logic [1:0] req_prv(input int id);
    return 2'(id % 4);
  endfunction

  // HPROT bit 0 marks data and bit 1 privileged
  function automatic logic [3:0] expect_hprot(input logic [1:0] prv);
    return (prv == 2'd0) ? 4'b0001 : 4'b0011;
  endfunction

  // HSIZE is log2 of the bytes per beat
  function automatic logic [2:0] expect_hsize(input logic [1:0] size);
    case (size)
      2'd0:    return 3'b000;
      2'd1:    return 3'b001;
      default: return 3'b010;
    endcase
  endfunction

  // Slave write of only the byte lanes that the transfer covers
  task automatic write_lanes(input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
    logic [3:0] be;
    case (size)
      3'd0:    be = 4'b0001 << addr[1:0];
      3'd1:    be = addr[1] ? 4'b1100 : 4'b0011;
      default: be = 4'b1111;
    endcase
    for (int i = 0; i < 4; i++)
    begin
      if (be[i])
      begin
        mem[addr[7:2]][8*i +: 8] = data[8*i +: 8];
      end
    end
  endtask

  task automatic load_requests();
    int fd, n;
    string line;
    logic [31:0] f_we, f_size, f_adr, f_wd, f_rd, f_wait, f_err, f_mis;
    fd = $fopen("dv/dmem_input.txt", "r");
    if (fd == 0)
      abort_run("cannot open the request file dv/dmem_input.txt");
    nreq = 0;
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 2 && line.substr(0, 1) != "//")
      begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                    f_we, f_size, f_adr, f_wd, f_rd, f_wait, f_err, f_mis);
        if (n != 8 || nreq >= MAX_REQ)
          abort_run("request file holds a malformed line");
        r_we[nreq]    = f_we[0];
        r_size[nreq]  = f_size[1:0];
        r_adr[nreq]   = f_adr;
        r_wdata[nreq] = f_wd;
        r_rdata[nreq] = f_rd;
        r_err[nreq]   = f_err[0];
        r_mis[nreq]   = f_mis[0];
        // F picks 0 to 3 wait states at random
        r_waits[nreq] = (f_wait == 32'hf) ? ($random(seed) & 3) : int'(f_wait);
        nreq++;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_request(input int id);
    cur_id    = id;
    dmem_req  = 1'b1;
    dmem_adr  = r_adr[id];
    dmem_size = biu_pkg::biu_size_t'(r_size[id]);
    dmem_we   = r_we[id];
    dmem_d    = r_wdata[id];
    dmem_prv  = req_prv(id);
  endtask

  task automatic wait_accept();
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
        abort_run("request was never accepted");
    end
    while (!dmem_req_ack);
  endtask

  //////////////////////////////////////////////////////////
  // Monitor, checker and slave on the falling edge
  //////////////////////////////////////////////////////////
  always @(posedge clk)
  begin
    cycle = cycle + 1;
  end

  // Slave outputs change just after the edge
  always @(posedge clk)
  begin
    #2;
    hready = nx_hready;
    hresp  = nx_hresp;
    hrdata = nx_hrdata;
  end

  always @(negedge clk)
  begin : bus_monitor
    int id;
    if (rst_n)
    begin
      compare_value("hburst_single", 32'(BURST_SINGLE), 32'(hburst));
      compare_value("hmastlock_low", 32'd0, 32'(hmastlock));
      compare_value("req_ack_follows_hready", 32'(hready), 32'(dmem_req_ack));

      // Completions in acceptance order
      if (dmem_ack)
      begin
        if (pend_q.size() == 0)
          abort_run("acknowledge with no request outstanding");
        id = pend_q.pop_front();
        compare_value(req_name(id, "err"), 32'(r_err[id]), 32'(dmem_err));
        compare_value(req_name(id, "misaligned"), 32'(r_mis[id]), 32'(dmem_misaligned));
        if (!r_we[id] && !r_err[id] && !r_mis[id])
          compare_value(req_name(id, "rdata"), r_rdata[id], dmem_q);
        // 3 cycles plus one per stalled bus cycle
        compare_value(req_name(id, "latency"), 32'(3 + stalls[id]),
                      32'(cycle + 1 - acc_edge[id]));
      end
      else if (dmem_err || dmem_misaligned)
        abort_run("error or misaligned flag without acknowledge");

      if (!hready)
      begin
        foreach (pend_q[k])
          stalls[pend_q[k]] = stalls[pend_q[k]] + 1;
      end

      // Address phase attributes
      if (htrans == TRANS_NONSEQ)
      begin
        if (bus_q.size() == 0)
          abort_run("NONSEQ transfer with no aligned request outstanding");
        id = bus_q[0];
        compare_value(req_name(id, "haddr"), r_adr[id], haddr);
        compare_value(req_name(id, "hwrite"), 32'(r_we[id]), 32'(hwrite));
        compare_value(req_name(id, "hsize"), 32'(expect_hsize(r_size[id])), 32'(hsize));
        compare_value(req_name(id, "hprot"), 32'(expect_hprot(req_prv(id))), 32'(hprot));
      end
      else
        compare_value("htrans_idle", 32'(TRANS_IDLE), 32'(htrans));

      // Slave data phase ends at the coming edge
      if (hready)
      begin
        if (dp_active && dp_write && !dp_err)
        begin
          compare_value(req_name(dp_id, "hwdata"), r_wdata[dp_id], hwdata);
          write_lanes(dp_addr, dp_size, hwdata);
        end
        dp_active = 1'b0;
        if (htrans == TRANS_NONSEQ)
        begin
          dp_id     = bus_q.pop_front();
          dp_active = 1'b1;
          dp_addr   = haddr;
          dp_write  = hwrite;
          dp_size   = hsize;
          dp_waits  = r_waits[dp_id];
          dp_err    = r_err[dp_id];
          err_half  = 1'b0;
        end
      end

      // Response for the next cycle
      if (!dp_active)
      begin
        nx_hready = 1'b1;
        nx_hresp  = 1'b0;
      end
      else if (dp_waits > 0)
      begin
        nx_hready = 1'b0;
        nx_hresp  = 1'b0;
        dp_waits--;
      end
      else if (dp_err && !err_half)
      begin
        // First of the two ERROR cycles
        nx_hready = 1'b0;
        nx_hresp  = 1'b1;
        err_half  = 1'b1;
      end
      else
      begin
        nx_hready = 1'b1;
        nx_hresp  = dp_err;
        nx_hrdata = mem[dp_addr[7:2]];
      end

      // Acceptance at the coming edge
      if (dmem_req && dmem_req_ack)
      begin
        acc_edge[cur_id] = cycle + 1;
        stalls[cur_id]   = 0;
        pend_q.push_back(cur_id);
        if (!r_mis[cur_id])
          bus_q.push_back(cur_id);
      end
    end
  end

  //////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////
  initial
  begin : driver
    int n;
    dmem_req  = 1'b0;
    dmem_adr  = '0;
    dmem_size = biu_pkg::BYTE;
    dmem_we   = 1'b0;
    dmem_d    = '0;
    dmem_prv  = '0;
    seed      = 32'hd84405fe;
    // Fill pattern from the word address
    for (int i = 0; i < 64; i++)
      mem[i] = {8'ha5, 8'(i), 8'h3c, 8'(i * 4)};
    load_requests();

    n = 0;
    while (rst_n !== 1'b1)
    begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT)
        abort_run("reset was never released");
    end

    // Quiet bus while nothing is requested
    repeat (4)
    begin
      @(negedge clk);
      compare_value("idle_htrans", 32'(TRANS_IDLE), 32'(htrans));
      compare_value("idle_ack", 32'd0, 32'(dmem_ack));
    end

    // Requests back to back with the strobe held high
    for (int i = 0; i < nreq; i++)
    begin
      @(posedge clk);
      #2;
      drive_request(i);
      wait_accept();
    end
    @(posedge clk);
    #2;
    dmem_req = 1'b0;

    n = 0;
    while (pend_q.size() != 0)
    begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT)
        abort_run("requests still outstanding after the last one was accepted");
    end
    repeat (4) @(posedge clk);

    if (bus_q.size() == 0)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
      abort_run("an aligned request never appeared on the bus");
  end

endmodule : tb_dmem_ahb

// File: dv/tb_clock.sv
////////////////////////////////////////////////////////////
// Testbench clock and active-low reset for the DUT
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
)
(
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release just after an edge, like other inputs
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule : tb_clock

// File: source/dmem_ahb_top.sv
////////////////////////////////////////////////////////////
// Data memory path to AHB3-Lite: decode, bus master, response
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dmem_ahb_top #(
  parameter int XLEN = 32,
  parameter int ALEN = XLEN
)
(
  input  logic                  hclk_i,
  input  logic                  rst_n_i,

  // CPU data request
  input  logic                  dmem_req_i,
  input  logic [ALEN-1:0]       dmem_adr_i,
  input  biu_pkg::biu_size_t    dmem_size_i,
  input  logic                  dmem_we_i,
  input  logic [XLEN-1:0]       dmem_d_i,
  input  biu_pkg::prv_t         dmem_prv_i,
  output logic                  dmem_req_ack_o,

  // CPU completion
  output logic                  dmem_ack_o,
  output logic                  dmem_err_o,
  output logic                  dmem_misaligned_o,
  output logic [XLEN-1:0]       dmem_q_o,

  // AHB3-Lite master port
  output logic [ALEN-1:0]       haddr_o,
  output logic [XLEN-1:0]       hwdata_o,
  output logic                  hwrite_o,
  output ahb3lite_pkg::hsize_t  hsize_o,
  output ahb3lite_pkg::hburst_t hburst_o,
  output ahb3lite_pkg::hprot_t  hprot_o,
  output ahb3lite_pkg::htrans_t htrans_o,
  output logic                  hmastlock_o,
  input  logic [XLEN-1:0]       hrdata_i,
  input  logic                  hready_i,
  input  logic                  hresp_i
);

  ////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////
  logic                 dec_valid;
  logic                 dec_misaligned;
  ahb3lite_pkg::hsize_t dec_hsize;
  ahb3lite_pkg::hprot_t dec_hprot;

  logic                 dphase_valid;
  logic                 dphase_misaligned;

  // Request check and AHB attribute mapping
  dmem_decode #(
    .ALEN ( ALEN )
  )
  decode_i (
    .dmem_req_i       ( dmem_req_i     ),
    .dmem_adr_i       ( dmem_adr_i     ),
    .dmem_size_i      ( dmem_size_i    ),
    .dmem_prv_i       ( dmem_prv_i     ),
    .dec_valid_o      ( dec_valid      ),
    .dec_misaligned_o ( dec_misaligned ),
    .dec_hsize_o      ( dec_hsize      ),
    .dec_hprot_o      ( dec_hprot      )
  );

  // Pipelined bus master
  ahb_master #(
    .XLEN ( XLEN ),
    .ALEN ( ALEN )
  )
  master_i (
    .hclk_i              ( hclk_i            ),
    .rst_n_i             ( rst_n_i           ),
    .dec_valid_i         ( dec_valid         ),
    .dec_misaligned_i    ( dec_misaligned    ),
    .dec_hsize_i         ( dec_hsize         ),
    .dec_hprot_i         ( dec_hprot         ),
    .dmem_adr_i          ( dmem_adr_i        ),
    .dmem_we_i           ( dmem_we_i         ),
    .dmem_d_i            ( dmem_d_i          ),
    .dmem_req_ack_o      ( dmem_req_ack_o    ),
    .hready_i            ( hready_i          ),
    .hresp_i             ( hresp_i           ),
    .haddr_o             ( haddr_o           ),
    .hwdata_o            ( hwdata_o          ),
    .hwrite_o            ( hwrite_o          ),
    .hsize_o             ( hsize_o           ),
    .hburst_o            ( hburst_o          ),
    .hprot_o             ( hprot_o           ),
    .htrans_o            ( htrans_o          ),
    .hmastlock_o         ( hmastlock_o       ),
    .dphase_valid_o      ( dphase_valid      ),
    .dphase_misaligned_o ( dphase_misaligned )
  );

  // In-order completion
  dmem_response #(
    .XLEN ( XLEN )
  )
  response_i (
    .hclk_i              ( hclk_i            ),
    .rst_n_i             ( rst_n_i           ),
    .dphase_valid_i      ( dphase_valid      ),
    .dphase_misaligned_i ( dphase_misaligned ),
    .hready_i            ( hready_i          ),
    .hresp_i             ( hresp_i           ),
    .hrdata_i            ( hrdata_i          ),
    .dmem_ack_o          ( dmem_ack_o        ),
    .dmem_err_o          ( dmem_err_o        ),
    .dmem_misaligned_o   ( dmem_misaligned_o ),
    .dmem_q_o            ( dmem_q_o          )
  );

endmodule : dmem_ahb_top

// File: source/dmem_response.sv
////////////////////////////////////////////////////////////
// Completion stage, one acknowledge per finished data phase
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dmem_response #(
  parameter int XLEN = 32
)
(
  input  logic            hclk_i,
  input  logic            rst_n_i,

  // Data phase status from the master
  input  logic            dphase_valid_i,
  input  logic            dphase_misaligned_i,

  // AHB3-Lite slave response
  input  logic            hready_i,
  input  logic            hresp_i,
  input  logic [XLEN-1:0] hrdata_i,

  // CPU completion
  output logic            dmem_ack_o,
  output logic            dmem_err_o,
  output logic            dmem_misaligned_o,
  output logic [XLEN-1:0] dmem_q_o
);

  logic dphase_done;

  // Data phase finished this cycle
  assign dphase_done = dphase_valid_i & hready_i;

  // Completion flags, single-cycle pulses
  always_ff @(posedge hclk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dmem_ack_o        <= 1'b0;
      dmem_err_o        <= 1'b0;
      dmem_misaligned_o <= 1'b0;
    end
    else
    begin
      dmem_ack_o        <= dphase_done;
      // HRESP only counts for a real transfer
      dmem_err_o        <= dphase_done & ~dphase_misaligned_i & hresp_i;
      dmem_misaligned_o <= dphase_done & dphase_misaligned_i;
    end
  end

  // Read data captured with the completion
  always_ff @(posedge hclk_i)
  begin
    if (dphase_done)
    begin
      dmem_q_o <= hrdata_i;
    end
  end

  a_err_xor_mis: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    !(dmem_err_o && dmem_misaligned_o));

endmodule : dmem_response

// File: source/ahb_master.sv
////////////////////////////////////////////////////////////
// AHB3-Lite single-transfer master with pipelined phases
// Fed by the request decoder, followed by the response stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_master #(
  parameter int XLEN = 32,
  parameter int ALEN = XLEN
)
(
  input  logic                  hclk_i,
  input  logic                  rst_n_i,

  // From decoder and CPU
  input  logic                  dec_valid_i,
  input  logic                  dec_misaligned_i,
  input  ahb3lite_pkg::hsize_t  dec_hsize_i,
  input  ahb3lite_pkg::hprot_t  dec_hprot_i,
  input  logic [ALEN-1:0]       dmem_adr_i,
  input  logic                  dmem_we_i,
  input  logic [XLEN-1:0]       dmem_d_i,
  output logic                  dmem_req_ack_o,

  // AHB3-Lite
  input  logic                  hready_i,
  input  logic                  hresp_i,
  output logic [ALEN-1:0]       haddr_o,
  output logic [XLEN-1:0]       hwdata_o,
  output logic                  hwrite_o,
  output ahb3lite_pkg::hsize_t  hsize_o,
  output ahb3lite_pkg::hburst_t hburst_o,
  output ahb3lite_pkg::hprot_t  hprot_o,
  output ahb3lite_pkg::htrans_t htrans_o,
  output logic                  hmastlock_o,

  // Slot now in data phase
  output logic                  dphase_valid_o,
  output logic                  dphase_misaligned_o
);

  ////////////////////////////////////////////////////////////
  // Phase registers
  ////////////////////////////////////////////////////////////
  logic            ap_slot;
  logic            ap_misaligned;
  logic [XLEN-1:0] ap_wdata;

  // Strobe is taken whenever the bus moves on
  assign dmem_req_ack_o = hready_i;

  // Slot occupancy, both stages advance together on HREADY
  always_ff @(posedge hclk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ap_slot             <= 1'b0;
      ap_misaligned       <= 1'b0;
      dphase_valid_o      <= 1'b0;
      dphase_misaligned_o <= 1'b0;
    end
    else if (hready_i)
    begin
      ap_slot             <= dec_valid_i;
      ap_misaligned       <= dec_valid_i & dec_misaligned_i;
      dphase_valid_o      <= ap_slot;
      dphase_misaligned_o <= ap_misaligned;
    end
  end

  // Address and write data payload
  always_ff @(posedge hclk_i)
  begin
    if (hready_i)
    begin
      haddr_o  <= dmem_adr_i;
      hwrite_o <= dmem_we_i;
      hsize_o  <= dec_hsize_i;
      hprot_o  <= dec_hprot_i;
      ap_wdata <= dmem_d_i;
      // Write data follows its address one phase later
      hwdata_o <= ap_wdata;
    end
  end

  // Misaligned or empty slots stay IDLE on the bus
  assign htrans_o    = (ap_slot && !ap_misaligned) ? ahb3lite_pkg::HTRANS_NONSEQ :
                                                     ahb3lite_pkg::HTRANS_IDLE;
  assign hburst_o    = ahb3lite_pkg::HBURST_SINGLE;
  assign hmastlock_o = 1'b0;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Decoder filtering keeps every bus address aligned
  a_haddr_aligned: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    (htrans_o == ahb3lite_pkg::HTRANS_NONSEQ) |->
      ((hsize_o == ahb3lite_pkg::HSIZE_B8) ||
       (hsize_o == ahb3lite_pkg::HSIZE_B16 && !haddr_o[0]) ||
       (hsize_o == ahb3lite_pkg::HSIZE_B32 && haddr_o[1:0] == 2'b00)));

  // Stalled address phase holds
  a_aphase_stable: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    (!hready_i && htrans_o == ahb3lite_pkg::HTRANS_NONSEQ) |=>
      $stable({htrans_o, haddr_o, hwrite_o, hsize_o, hprot_o}));

  // Slave ends an ERROR in exactly two cycles
  a_error_two_cycle: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    (hresp_i && !hready_i) |=> (hresp_i && hready_i));

endmodule : ahb_master

// File: source/dmem_decode.sv
////////////////////////////////////////////////////////////
// Data request decoder: misalignment check, HSIZE and HPROT
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dmem_decode #(
  parameter int ALEN = 32
)
(
  input  logic                 dmem_req_i,
  input  logic [ALEN-1:0]      dmem_adr_i,
  input  biu_pkg::biu_size_t   dmem_size_i,
  input  biu_pkg::prv_t        dmem_prv_i,

  output logic                 dec_valid_o,
  output logic                 dec_misaligned_o,
  output ahb3lite_pkg::hsize_t dec_hsize_o,
  output ahb3lite_pkg::hprot_t dec_hprot_o
);

  logic misaligned;

  // Size to HSIZE, alignment from the low address bits
  always_comb
  begin
    case (dmem_size_i)
      biu_pkg::BYTE:
      begin
        dec_hsize_o = ahb3lite_pkg::HSIZE_B8;
        misaligned  = 1'b0;
      end
      biu_pkg::HWORD:
      begin
        dec_hsize_o = ahb3lite_pkg::HSIZE_B16;
        misaligned  = dmem_adr_i[0];
      end
      biu_pkg::WORD:
      begin
        dec_hsize_o = ahb3lite_pkg::HSIZE_B32;
        misaligned  = |dmem_adr_i[1:0];
      end
      default:
      begin
        // Reserved size, keep it off the bus
        dec_hsize_o = ahb3lite_pkg::HSIZE_B32;
        misaligned  = 1'b1;
      end
    endcase
  end

  assign dec_valid_o      = dmem_req_i;
  assign dec_misaligned_o = dmem_req_i & misaligned;

  // Always a data access; privileged unless user mode
  assign dec_hprot_o = (dmem_prv_i == biu_pkg::PRV_U) ? ahb3lite_pkg::HPROT_DATA :
                       (ahb3lite_pkg::HPROT_DATA | ahb3lite_pkg::HPROT_PRIVILEGED);

  // CPU never issues the reserved size encoding
  always_comb
  begin
    a_size_known: assert final (!dmem_req_i || dmem_size_i inside
      {biu_pkg::BYTE, biu_pkg::HWORD, biu_pkg::WORD});
  end

endmodule : dmem_decode

// File: source/ahb3lite_pkg.sv
////////////////////////////////////////////////////////////
// AHB3-Lite field widths and encodings for the bus master
////////////////////////////////////////////////////////////

package ahb3lite_pkg;

  //////////////////////////////////////////////////////////
  // Field widths
  //////////////////////////////////////////////////////////
  localparam int HTRANS_SIZE = 2;
  localparam int HSIZE_SIZE  = 3;
  localparam int HBURST_SIZE = 3;
  localparam int HPROT_SIZE  = 4;

  typedef logic [HTRANS_SIZE-1:0] htrans_t;
  typedef logic [HSIZE_SIZE-1:0]  hsize_t;
  typedef logic [HBURST_SIZE-1:0] hburst_t;
  typedef logic [HPROT_SIZE-1:0]  hprot_t;

  //////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////

  // Transfer type
  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_BUSY   = 2'b01;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;
  localparam htrans_t HTRANS_SEQ    = 2'b11;

  // Transfer size, bytes per beat
  localparam hsize_t HSIZE_B8  = 3'b000;
  localparam hsize_t HSIZE_B16 = 3'b001;
  localparam hsize_t HSIZE_B32 = 3'b010;
  localparam hsize_t HSIZE_B64 = 3'b011;

  // Burst type, only single beats used here
  localparam hburst_t HBURST_SINGLE = 3'b000;
  localparam hburst_t HBURST_INCR   = 3'b001;

  // Protection bits, used as masks
  localparam hprot_t HPROT_DATA       = 4'b0001;
  localparam hprot_t HPROT_PRIVILEGED = 4'b0010;
  localparam hprot_t HPROT_BUFFERABLE = 4'b0100;
  localparam hprot_t HPROT_CACHEABLE  = 4'b1000;

endpackage : ahb3lite_pkg

// File: source/biu_pkg.sv
////////////////////////////////////////////////////////////
// CPU-side access types of the data bus interface unit
// Size enum and privilege levels shared by decode and top
////////////////////////////////////////////////////////////

package biu_pkg;

  //////////////////////////////////////////////////////////
  // Access size
  //////////////////////////////////////////////////////////

  // Width of the CPU access size field
  localparam int BIU_SIZE_W = 2;

  // Size of one CPU load or store
  // Encoding 2'b11 is reserved and never driven by the CPU
  typedef enum logic [BIU_SIZE_W-1:0]
  {
    BYTE  = 2'b00,
    HWORD = 2'b01,
    WORD  = 2'b10
  } biu_size_t;

  //////////////////////////////////////////////////////////
  // Privilege level
  //////////////////////////////////////////////////////////

  // Width of the privilege field
  localparam int PRV_W = 2;

  // Current CPU privilege level
  typedef logic [PRV_W-1:0] prv_t;

  // User mode, the only non-privileged level
  localparam prv_t PRV_U = 2'd0;

  // Supervisor mode
  localparam prv_t PRV_S = 2'd1;

  // Hypervisor mode, reserved
  localparam prv_t PRV_H = 2'd2;

  // Machine mode
  localparam prv_t PRV_M = 2'd3;

endpackage : biu_pkg
